//--- src.f
verilog/sat_ctrl_pkg.sv
verilog/propagation_monitor.sv
verilog/learnt_lit_counter.sv
verilog/analyze_fsm.sv
verilog/backtrack_select.sv
verilog/sat_state_ctrl.sv
testbench/sat_state_ctrl_checker.sv
testbench/tb_sat_state_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_sat_state_ctrl -f src.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- testbench/tb_sat_state_ctrl.sv
// directed tests for the control core; needs a simulator with timing support, stops at first error
`timescale 1ns/100ps

module tb_sat_state_ctrl;

    logic                      clk;
    logic                      rst;
    sat_ctrl_pkg::prop_flags_t flags;
    logic                      apply_imply;
    logic                      apply_analyze;
    logic                      apply_bkt;
    sat_ctrl_pkg::lvl_hint_t   hint;
    logic                      base_lvl_en;
    sat_ctrl_pkg::lvl_t        base_lvl;
    logic                      done_imply;
    logic                      find_conflict;
    logic                      add_learntc_en;
    logic                      done_analyze;
    sat_ctrl_pkg::bkt_result_t bkt;
    logic                      done_bkt;

    sat_state_ctrl dut0 (
        .clk              (clk),
        .rst              (rst),
        .flags_i          (flags),
        .apply_imply_i    (apply_imply),
        .apply_analyze_i  (apply_analyze),
        .apply_bkt_i      (apply_bkt),
        .hint_i           (hint),
        .base_lvl_en_i    (base_lvl_en),
        .base_lvl_i       (base_lvl),
        .done_imply_o     (done_imply),
        .find_conflict_o  (find_conflict),
        .add_learntc_en_o (add_learntc_en),
        .done_analyze_o   (done_analyze),
        .bkt_o            (bkt),
        .done_bkt_o       (done_bkt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            abort_run($sformatf("Mismatch in %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic reset_values_test();
        check("reset done_imply", 64'(0), 64'(done_imply));
        check("reset find_conflict", 64'(0), 64'(find_conflict));
        check("reset add_learntc_en", 64'(0), 64'(add_learntc_en));
        check("reset done_analyze", 64'(0), 64'(done_analyze));
        check("reset bkt", 64'(0), 64'(bkt));
        check("reset done_bkt", 64'(0), 64'(done_bkt));
    endtask

    task automatic imply_settle_test();
        sat_ctrl_pkg::var_vec_t v1;
        v1 = 8'($urandom);
        next_cycle();
        flags.imply = v1;
        apply_imply = 1'b1;
        #1;
        check("imply first cycle", 64'(0), 64'(done_imply));
        next_cycle();
        check("imply settled", 64'(1), 64'(done_imply));
        flags.imply = ~v1;
        #1;
        check("imply changed", 64'(0), 64'(done_imply));
        next_cycle();
        check("imply settled again", 64'(1), 64'(done_imply));
        // a conflict ends propagation even while implications still move
        flags.imply = v1 ^ 8'h01;
        flags.conflict = 8'h10;
        #1;
        check("conflict find", 64'(1), 64'(find_conflict));
        check("conflict done_imply", 64'(1), 64'(done_imply));
        next_cycle();
        apply_imply = 1'b0;
        flags = '0;
        #1;
        check("conflict cleared", 64'(0), 64'(find_conflict));
    endtask

    // new imply request with one or two conflict discoveries, then a stable vector
    task automatic load_conflicts(input bit two_lits);
        sat_ctrl_pkg::var_vec_t first;
        first = 8'(8'd1 << ($urandom % 8));
        apply_imply = 1'b0;
        flags = '0;
        next_cycle();
        apply_imply = 1'b1;
        flags.conflict = first;
        #1;
        check("conflict flag", 64'(1), 64'(find_conflict));
        next_cycle();
        if (two_lits) begin
            flags.conflict = first | {first[6:0], first[7]};
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic run_analysis(input string name, input int exp_adds, input int hold);
        int edges;
        int adds;
        edges = 0;
        adds = 0;
        apply_analyze = 1'b1;
        while (!done_analyze) begin
            next_cycle();
            edges++;
            if (add_learntc_en) begin
                adds++;
            end
            if (edges > 20) begin
                abort_run({name, ": no done_analyze_o within 20 cycles"});
            end
        end
        // sampling edge, FIND_LEARNTC, ADD_LEARNTC, ANALYZE_DONE
        check({name, " edges to done"}, 64'(4), 64'(edges));
        check({name, " learnt clause strobes"}, 64'(exp_adds), 64'(adds));
        repeat (hold) begin
            next_cycle();
            check({name, " done while held"}, 64'(0), 64'(done_analyze));
        end
        apply_analyze = 1'b0;
        next_cycle();
    endtask

    task automatic analysis_lits_test();
        load_conflicts(1'b1);
        run_analysis("two literals", 1, 0);
        load_conflicts(1'b0);
        run_analysis("one literal", 0, 0);
    endtask

    // each branch of the level rule is hit twice
    task automatic bkt_rule_test();
        sat_ctrl_pkg::lvl_t exp_lvl;
        for (int i = 0; i < 6; i++) begin
            base_lvl = 16'($urandom % 64) + 16'd1;
            base_lvl_en = 1'b1;
            next_cycle();
            base_lvl_en = 1'b0;
            hint.ls_bin = 10'($urandom);
            case (i % 3)
                0: begin
                    // deeper than base, no level-state suggestion
                    hint.max_lvl = base_lvl + 16'($urandom % 64) + 16'd1;
                    hint.ls_lvl = '0;
                    exp_lvl = base_lvl;
                end
                1: begin
                    hint.max_lvl = base_lvl + 16'($urandom % 64) + 16'd1;
                    hint.ls_lvl = 16'($urandom % 1000) + 16'd1;
                    exp_lvl = hint.ls_lvl;
                end
                default: begin
                    // at or below base
                    hint.max_lvl = 16'($urandom % (base_lvl + 1));
                    hint.ls_lvl = 16'($urandom);
                    exp_lvl = hint.max_lvl;
                end
            endcase
            load_conflicts((i % 2) == 1);
            run_analysis("backtrack rule", i % 2, 0);
            check("backtrack level", 64'(exp_lvl), 64'(bkt.lvl));
            check("backtrack bin", 64'(hint.ls_bin), 64'(bkt.bin));
        end
    endtask

    task automatic wait_release_test();
        load_conflicts(1'b1);
        run_analysis("held request", 1, 5);
        // counter keeps its value while the imply request stays up
        run_analysis("second request", 1, 0);
    endtask

    task automatic bkt_ack_test();
        next_cycle();
        apply_bkt = 1'b1;
        #1;
        check("backtrack ack high", 64'(1), 64'(done_bkt));
        next_cycle();
        apply_bkt = 1'b0;
        #1;
        check("backtrack ack low", 64'(0), 64'(done_bkt));
    endtask

    initial begin
        void'($urandom(19));
        rst = 1'b0;
        flags = '0;
        apply_imply = 1'b0;
        apply_analyze = 1'b0;
        apply_bkt = 1'b0;
        hint = '0;
        base_lvl_en = 1'b0;
        base_lvl = '0;
        repeat (3) @(posedge clk);
        #2;
        // no acknowledge while reset is applied
        apply_bkt = 1'b1;
        #1;
        check("reset done_bkt held off", 64'(0), 64'(done_bkt));
        apply_bkt = 1'b0;
        @(posedge clk);
        #2;
        rst = 1'b1;
        #1;
        reset_values_test();
        imply_settle_test();
        analysis_lits_test();
        bkt_rule_test();
        wait_release_test();
        bkt_ack_test();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- testbench/sat_state_ctrl_checker.sv
// output timing properties of the control core; only active when assertions are compiled in
`timescale 1ns/100ps

module sat_state_ctrl_checker (
    input logic clk,
    input logic rst,
    input logic apply_bkt_i,
    input logic add_learntc_en_o,
    input logic done_analyze_o,
    input logic done_bkt_o
);

    // one result strobe per analysis
    done_analyze_single: assert property (
        @(posedge clk) disable iff (!rst) done_analyze_o |=> !done_analyze_o
    ) else $error("done_analyze_o stayed high for two cycles");

    add_then_done: assert property (
        @(posedge clk) disable iff (!rst) add_learntc_en_o |=> done_analyze_o
    ) else $error("add_learntc_en_o was not followed by done_analyze_o");

    bkt_ack_same_cycle: assert property (
        @(posedge clk) disable iff (!rst) done_bkt_o == apply_bkt_i
    ) else $error("done_bkt_o differs from apply_bkt_i");

endmodule

bind sat_state_ctrl sat_state_ctrl_checker chk0 (
    .clk              (clk),
    .rst              (rst),
    .apply_bkt_i      (apply_bkt_i),
    .add_learntc_en_o (add_learntc_en_o),
    .done_analyze_o   (done_analyze_o),
    .done_bkt_o       (done_bkt_o)
);

//--- verilog/sat_state_ctrl.sv
// state list control core; flags and level-state results come in as inputs, no back-pressure
`timescale 1ns/100ps

module sat_state_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  sat_ctrl_pkg::prop_flags_t flags_i,
    input  logic                      apply_imply_i,
    input  logic                      apply_analyze_i,
    input  logic                      apply_bkt_i,
    input  sat_ctrl_pkg::lvl_hint_t   hint_i,
    input  logic                      base_lvl_en_i,
    input  sat_ctrl_pkg::lvl_t        base_lvl_i,
    output logic                      done_imply_o,
    output logic                      find_conflict_o,
    output logic                      add_learntc_en_o,
    output logic                      done_analyze_o,
    output sat_ctrl_pkg::bkt_result_t bkt_o,
    output logic                      done_bkt_o
);

    logic imply_start;
    logic conflict_changed;
    logic multi_lit;
    logic capture;

    propagation_monitor u_prop_mon (
        .clk                (clk),
        .rst                (rst),
        .flags_i            (flags_i),
        .apply_imply_i      (apply_imply_i),
        .done_imply_o       (done_imply_o),
        .find_conflict_o    (find_conflict_o),
        .imply_start_o      (imply_start),
        .conflict_changed_o (conflict_changed)
    );

    // find_conflict_o doubles as the any-conflict flag
    learnt_lit_counter u_lit_cnt (
        .clk                (clk),
        .rst                (rst),
        .imply_start_i      (imply_start),
        .any_conflict_i     (find_conflict_o),
        .conflict_changed_i (conflict_changed),
        .multi_lit_o        (multi_lit)
    );

    analyze_fsm u_analyze (
        .clk                (clk),
        .rst                (rst),
        .apply_analyze_i    (apply_analyze_i),
        .conflict_changed_i (conflict_changed),
        .multi_lit_i        (multi_lit),
        .add_learntc_en_o   (add_learntc_en_o),
        .done_analyze_o     (done_analyze_o),
        .capture_o          (capture)
    );

    backtrack_select u_bkt_sel (
        .clk           (clk),
        .rst           (rst),
        .hint_i        (hint_i),
        .base_lvl_en_i (base_lvl_en_i),
        .base_lvl_i    (base_lvl_i),
        .capture_i     (capture),
        .apply_bkt_i   (apply_bkt_i),
        .bkt_o         (bkt_o),
        .done_bkt_o    (done_bkt_o)
    );

endmodule

//--- verilog/backtrack_select.sv
// backtrack level taken from hint_i in the capture cycle; done_bkt_o is the same-cycle acknowledge
`timescale 1ns/100ps

module backtrack_select (
    input  logic                      clk,
    input  logic                      rst,
    input  sat_ctrl_pkg::lvl_hint_t   hint_i,
    input  logic                      base_lvl_en_i,
    input  sat_ctrl_pkg::lvl_t        base_lvl_i,
    input  logic                      capture_i,
    input  logic                      apply_bkt_i,
    output sat_ctrl_pkg::bkt_result_t bkt_o,
    output logic                      done_bkt_o
);

    sat_ctrl_pkg::lvl_t base_lvl_q;
    sat_ctrl_pkg::lvl_t bkt_lvl;

    always_ff @(posedge clk) begin
        if (!rst) begin
            base_lvl_q <= '0;
        end else if (base_lvl_en_i) begin
            base_lvl_q <= base_lvl_i;
        end
    end

    // never go above the base level unless the level array says so
    always_comb begin
        if (hint_i.max_lvl <= base_lvl_q) begin
            bkt_lvl = hint_i.max_lvl;
        end else if (hint_i.ls_lvl == '0) begin
            bkt_lvl = base_lvl_q;
        end else begin
            bkt_lvl = hint_i.ls_lvl;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_o <= '0;
        end else if (capture_i) begin
            bkt_o.bin <= hint_i.ls_bin;
            bkt_o.lvl <= bkt_lvl;
        end
    end

    // backtrack of the current bin completes in one cycle, held off in reset
    assign done_bkt_o = rst && apply_bkt_i;

endmodule

//--- verilog/analyze_fsm.sv
// assumes apply_analyze_i is held until done_analyze_o has been seen; strobes are registered
`timescale 1ns/100ps

module analyze_fsm (
    input  logic clk,
    input  logic rst,
    input  logic apply_analyze_i,
    input  logic conflict_changed_i,
    input  logic multi_lit_i,
    output logic add_learntc_en_o,
    output logic done_analyze_o,
    output logic capture_o
);

    sat_ctrl_pkg::analyze_state_e state_q;
    sat_ctrl_pkg::analyze_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= sat_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            sat_ctrl_pkg::IDLE: begin
                if (apply_analyze_i) begin
                    state_d = sat_ctrl_pkg::FIND_LEARNTC;
                end
            end
            sat_ctrl_pkg::FIND_LEARNTC: begin
                // keep searching while the conflict set still moves
                if (!conflict_changed_i) begin
                    state_d = sat_ctrl_pkg::ADD_LEARNTC;
                end
            end
            sat_ctrl_pkg::ADD_LEARNTC: begin
                state_d = sat_ctrl_pkg::ANALYZE_DONE;
            end
            sat_ctrl_pkg::ANALYZE_DONE: begin
                state_d = sat_ctrl_pkg::ANALYZE_WAIT;
            end
            sat_ctrl_pkg::ANALYZE_WAIT: begin
                // controller drops the request once it has the result
                if (!apply_analyze_i) begin
                    state_d = sat_ctrl_pkg::IDLE;
                end
            end
            default: begin
                state_d = sat_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            add_learntc_en_o <= 1'b0;
            done_analyze_o   <= 1'b0;
        end else begin
            add_learntc_en_o <= (state_q == sat_ctrl_pkg::ADD_LEARNTC) && multi_lit_i;
            done_analyze_o   <= (state_q == sat_ctrl_pkg::ANALYZE_DONE);
        end
    end

    // result latched at the same edge that raises done_analyze_o
    assign capture_o = (state_q == sat_ctrl_pkg::ANALYZE_DONE);

endmodule

//--- verilog/learnt_lit_counter.sv
// counts conflict discoveries per imply request; the count saturates at no limit and wraps
`timescale 1ns/100ps

module learnt_lit_counter (
    input  logic clk,
    input  logic rst,
    input  logic imply_start_i,
    input  logic any_conflict_i,
    input  logic conflict_changed_i,
    output logic multi_lit_o
);

    logic [sat_ctrl_pkg::CNT_W-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt_q <= '0;
        end else if (imply_start_i) begin
            // a conflict already present at the start counts once
            cnt_q <= sat_ctrl_pkg::CNT_W'(any_conflict_i);
        end else if (any_conflict_i && conflict_changed_i) begin
            cnt_q <= cnt_q + sat_ctrl_pkg::CNT_W'(1);
        end
    end

    // learnt clause only worth adding with more than one literal
    assign multi_lit_o = (cnt_q > sat_ctrl_pkg::CNT_W'(1));

endmodule

//--- verilog/propagation_monitor.sv
// flag events are one cycle behind their inputs; done_imply_o needs apply_imply_i held a cycle
`timescale 1ns/100ps

module propagation_monitor (
    input  logic                      clk,
    input  logic                      rst,
    input  sat_ctrl_pkg::prop_flags_t flags_i,
    input  logic                      apply_imply_i,
    output logic                      done_imply_o,
    output logic                      find_conflict_o,
    output logic                      imply_start_o,
    output logic                      conflict_changed_o
);

    sat_ctrl_pkg::var_vec_t imply_pre;
    sat_ctrl_pkg::var_vec_t conflict_pre;
    logic                   apply_imply_dly;
    logic                   imply_settled;

    // previous-cycle copies of the flag vectors
    always_ff @(posedge clk) begin
        if (!rst) begin
            imply_pre    <= '0;
            conflict_pre <= '0;
        end else begin
            imply_pre    <= flags_i.imply;
            conflict_pre <= flags_i.conflict;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            apply_imply_dly <= 1'b0;
        end else begin
            apply_imply_dly <= apply_imply_i;
        end
    end

    assign find_conflict_o = |flags_i.conflict;

    // no new implications since last cycle
    assign imply_settled = (flags_i.imply == imply_pre);

    assign done_imply_o = apply_imply_dly && (imply_settled || find_conflict_o);

    // rising edge of the imply request
    assign imply_start_o = apply_imply_i && !apply_imply_dly;

    assign conflict_changed_o = (flags_i.conflict != conflict_pre);

endmodule

//--- verilog/sat_ctrl_pkg.sv
// shared sizes and types for the state list control core; fixed at 8 variables, no parameters
package sat_ctrl_pkg;

    // flag vector and field widths
    localparam int NUM_VARS = 8;
    localparam int LVL_W    = 16;
    localparam int BIN_W    = 10;
    localparam int CNT_W    = 6;

    typedef logic [NUM_VARS-1:0] var_vec_t;
    typedef logic [LVL_W-1:0]    lvl_t;
    typedef logic [BIN_W-1:0]    bin_t;

    // conflict analysis sequence
    typedef enum logic [2:0] {
        IDLE         = 3'd0,
        FIND_LEARNTC = 3'd1,
        ADD_LEARNTC  = 3'd2,
        ANALYZE_DONE = 3'd3,
        ANALYZE_WAIT = 3'd4
    } analyze_state_e;

    // per-variable flags from the variable array
    typedef struct packed {
        var_vec_t imply;
        var_vec_t conflict;
    } prop_flags_t;

    // level-state array results plus deepest conflicting level
    typedef struct packed {
        lvl_t max_lvl;
        // 0 means no suggestion
        lvl_t ls_lvl;
        bin_t ls_bin;
    } lvl_hint_t;

    // captured backtrack target
    typedef struct packed {
        bin_t bin;
        lvl_t lvl;
    } bkt_result_t;

endpackage
